// File: Bender.yml
package:
  name: user_io

sources:
  - files:
      - hdl/user_io_pkg.sv
      - hdl/spi_byte_port.sv
      - hdl/io_cmd_ctrl.sv
      - hdl/io_reg_bank.sv
      - hdl/ps2_tx_fifo.sv
      - hdl/user_io_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/user_io_tb.sv

// File: hdl/io_cmd_ctrl.sv
//////////////////////////////////////////////////
// io command controller
// follows command, length and payload bytes,
// steers register writes, ps2 pushes and replies
//////////////////////////////////////////////////

`timescale 1ns/1ps

module io_cmd_ctrl (
	input  logic                  ps2_clk,
	input  logic                  SPI_SS_IO,
	input  user_io_pkg::rx_byte_t rx,
	output user_io_pkg::byte_t    reply,
	output user_io_pkg::reg_wr_t  reg_wr,
	output logic                  kbd_push,
	output logic                  mouse_push,
	output user_io_pkg::byte_t    push_data
);
	import user_io_pkg::*;

	frame_state_e state;
	cmd_e         cmd_q;
	byte_t        len_q;
	byte_t        idx_q;
	logic         payload_stb;
	logic         is_reg_cmd;

	// anything not listed becomes cmd_none and is skipped by length
	function automatic cmd_e decode_cmd(input byte_t code);
		cmd_e c;
		case (code)
			cmd_but_sw, cmd_joy_0, cmd_joy_1, cmd_mouse, cmd_kbd,
			cmd_get_conf, cmd_status, cmd_analog:
				c = cmd_e'(code);
			default:
				c = cmd_none;
		endcase
		return c;
	endfunction

	// framing fsm
	always_ff @(posedge ps2_clk or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			state <= st_cmd;
			cmd_q <= cmd_none;
			len_q <= '0;
			idx_q <= '0;
		end else if (rx.stb) begin
			case (state)
				st_cmd: begin
					cmd_q <= decode_cmd(rx.data);
					state <= st_len;
				end
				st_len: begin
					len_q <= rx.data;
					idx_q <= '0;
					// zero length means no payload at all
					state <= (rx.data == 8'd0) ? st_cmd : st_data;
				end
				st_data: begin
					idx_q <= idx_q + 8'd1;
					if (idx_q + 8'd1 == len_q)
						state <= st_cmd;
				end
				default: state <= st_cmd;
			endcase
		end
	end

	// payload byte arriving right now
	assign payload_stb = rx.stb && (state == st_data);

	assign is_reg_cmd = (cmd_q == cmd_but_sw) || (cmd_q == cmd_joy_0) ||
		(cmd_q == cmd_joy_1) || (cmd_q == cmd_status) || (cmd_q == cmd_analog);

	// register write, taken by the bank on the next edge
	assign reg_wr = '{
		stb:  payload_stb && is_reg_cmd,
		cmd:  cmd_q,
		idx:  idx_q,
		data: rx.data
	};

	// ps2 bytes go straight to the fifos
	assign kbd_push   = payload_stb && (cmd_q == cmd_kbd);
	assign mouse_push = payload_stb && (cmd_q == cmd_mouse);
	assign push_data  = rx.data;

	// reply for the next spi byte, from the state already updated
	always_comb begin
		reply = '0;
		if (state == st_cmd)
			reply = core_type;
		else if ((state == st_data) && (cmd_q == cmd_get_conf) && (idx_q < conf_len))
			reply = conf_text[8*(conf_len-1-int'(idx_q)) +: 8];
	end

	// a payload byte has exactly one destination
	a_one_sink: assert property (
		@(posedge ps2_clk) disable iff (SPI_SS_IO)
		!(reg_wr.stb && (kbd_push || mouse_push))
	);

endmodule

// File: hdl/io_reg_bank.sv
//////////////////////////////////////////////////
// io register bank
// buttons, switches, joysticks, analog sticks
// and the status byte written by the controller
//////////////////////////////////////////////////

`timescale 1ns/1ps

module io_reg_bank (
	input  logic                 ps2_clk,
	input  logic                 SPI_SS_IO,
	input  user_io_pkg::reg_wr_t reg_wr,
	output logic [1:0]           buttons,
	output logic [1:0]           switches,
	output logic                 scandoubler_disable,
	output user_io_pkg::byte_t   joystick_0,
	output user_io_pkg::byte_t   joystick_1,
	output user_io_pkg::byte_t   status,
	output user_io_pkg::word_t   joystick_analog_0,
	output user_io_pkg::word_t   joystick_analog_1
);
	import user_io_pkg::*;

	// buttons [1:0], switches [3:2], scandoubler [4]
	logic [4:0] but_sw;
	// analog target, latched from payload byte 0
	byte_t      stick_idx;

	assign buttons             = but_sw[1:0];
	assign switches            = but_sw[3:2];
	assign scandoubler_disable = but_sw[4];

	always_ff @(posedge ps2_clk or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			but_sw            <= '0;
			joystick_0        <= '0;
			joystick_1        <= '0;
			status            <= '0;
			stick_idx         <= '0;
			joystick_analog_0 <= '0;
			joystick_analog_1 <= '0;
		end else if (reg_wr.stb) begin
			// longer payloads just overwrite, the last byte wins
			case (reg_wr.cmd)
				cmd_but_sw: but_sw     <= reg_wr.data[4:0];
				cmd_joy_0:  joystick_0 <= reg_wr.data;
				cmd_joy_1:  joystick_1 <= reg_wr.data;
				cmd_status: status     <= reg_wr.data;
				cmd_analog: begin
					// byte 0 picks the stick, 1 is x, 2 is y
					if (reg_wr.idx == 8'd0)
						stick_idx <= reg_wr.data;
					else if ((reg_wr.idx == 8'd1) && (stick_idx == 8'd0))
						joystick_analog_0[15:8] <= reg_wr.data;
					else if ((reg_wr.idx == 8'd1) && (stick_idx == 8'd1))
						joystick_analog_1[15:8] <= reg_wr.data;
					else if ((reg_wr.idx == 8'd2) && (stick_idx == 8'd0))
						joystick_analog_0[7:0] <= reg_wr.data;
					else if ((reg_wr.idx == 8'd2) && (stick_idx == 8'd1))
						joystick_analog_1[7:0] <= reg_wr.data;
				end
				default: ;
			endcase
		end
	end

endmodule

// File: hdl/ps2_tx_fifo.sv
//////////////////////////////////////////////////
// ps2 transmit channel
// small byte fifo in front of a device-to-host
// ps2 serializer: start, 8 data, parity, stop
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ps2_tx_fifo (
	input  logic               ps2_clk,
	input  logic               SPI_SS_IO,
	input  logic               push,
	input  user_io_pkg::byte_t push_data,
	output logic               ps2_dev_clk,
	output logic               ps2_dev_data
);
	import user_io_pkg::*;

	// storage, pointers carry one extra wrap bit
	byte_t                  mem [2**ps2_fifo_bits];
	logic [ps2_fifo_bits:0] wptr;
	logic [ps2_fifo_bits:0] rptr;
	logic                   empty;
	logic                   full;

	// transmitter
	logic [3:0] tx_state;
	byte_t      tx_byte;
	logic       parity;
	logic       tx_start;

	assign empty = (wptr == rptr);
	assign full  = (wptr[ps2_fifo_bits] != rptr[ps2_fifo_bits]) &&
		(wptr[ps2_fifo_bits-1:0] == rptr[ps2_fifo_bits-1:0]);

	// idle and something queued
	assign tx_start = (tx_state == 4'd0) && !empty;

	// clock runs only while a frame is on the wire
	assign ps2_dev_clk = ps2_clk | (tx_state == 4'd0);

	always_ff @(posedge ps2_clk or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			wptr         <= '0;
			rptr         <= '0;
			tx_state     <= 4'd0;
			parity       <= 1'b1;
			ps2_dev_data <= 1'b1;
		end else begin
			// a push into a full fifo is lost
			if (push && !full)
				wptr <= wptr + 1'b1;

			if (tx_start) begin
				rptr         <= rptr + 1'b1;
				parity       <= 1'b1;
				// start bit
				ps2_dev_data <= 1'b0;
				tx_state     <= 4'd1;
			end else if (tx_state != 4'd0) begin
				if (tx_state <= 4'd8) begin
					// data bits, lsb first
					ps2_dev_data <= tx_byte[0];
					if (tx_byte[0])
						parity <= ~parity;
				end else if (tx_state == 4'd9) begin
					ps2_dev_data <= parity;
				end else if (tx_state == 4'd10) begin
					// stop bit
					ps2_dev_data <= 1'b1;
				end
				tx_state <= (tx_state == ps2_last_state) ? 4'd0 : tx_state + 4'd1;
			end
		end
	end

	// fifo array and shift register
	always_ff @(posedge ps2_clk) begin
		if (push && !full)
			mem[wptr[ps2_fifo_bits-1:0]] <= push_data;

		if (tx_start)
			tx_byte <= mem[rptr[ps2_fifo_bits-1:0]];
		else if ((tx_state != 4'd0) && (tx_state <= 4'd8))
			tx_byte <= {1'b0, tx_byte[7:1]};
	end

	a_state_range: assert property (
		@(posedge ps2_clk) disable iff (SPI_SS_IO)
		tx_state <= ps2_last_state
	);

	// the host is expected to pace its bursts to the fifo depth
	a_no_overflow: assert property (
		@(posedge ps2_clk) disable iff (SPI_SS_IO)
		!(push && full)
	);

endmodule

// File: hdl/spi_byte_port.sv
//////////////////////////////////////////////////
// spi byte port
// oversamples the spi lines on ps2_clk, builds
// mosi bytes and shifts the reply out on miso
//////////////////////////////////////////////////

`timescale 1ns/1ps

module spi_byte_port (
	input  logic                 ps2_clk,
	input  logic                 SPI_SS_IO,
	input  logic                 spi_clk,
	input  logic                 spi_mosi,
	input  user_io_pkg::byte_t   reply,
	output logic                 spi_miso,
	output user_io_pkg::rx_byte_t rx
);
	import user_io_pkg::*;

	// two flop synchronizers plus history for edge detect
	logic [1:0] sck_sync;
	logic [1:0] mosi_sync;
	logic       sck_prev;
	logic       sck_rise;
	logic       sck_fall;

	// receive side
	logic [2:0] bit_cnt;
	logic [6:0] rx_sh;
	logic       rx_stb;
	byte_t      rx_data;

	// transmit side
	byte_t      tx_sh;
	logic       load_q;

	assign sck_rise = sck_sync[1] & ~sck_prev;
	assign sck_fall = ~sck_sync[1] & sck_prev;

	assign rx = '{stb: rx_stb, data: rx_data};

	// spi clock idles high, so the sync chain resets to 1
	// and no false edge shows up when reset drops
	always_ff @(posedge ps2_clk or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			sck_sync  <= 2'b11;
			sck_prev  <= 1'b1;
			mosi_sync <= 2'b00;
			bit_cnt   <= 3'd0;
			rx_stb    <= 1'b0;
			load_q    <= 1'b1;
			spi_miso  <= 1'b0;
		end else begin
			sck_sync  <= {sck_sync[0], spi_clk};
			mosi_sync <= {mosi_sync[0], spi_mosi};
			sck_prev  <= sck_sync[1];

			// byte done on the eighth rising edge
			rx_stb <= sck_rise && (bit_cnt == 3'd7);
			if (sck_rise)
				bit_cnt <= bit_cnt + 3'd1;

			// reload one cycle after the strobe, once the
			// controller has moved on to the next byte
			load_q <= rx_stb;

			// miso follows the falling edge, msb first
			if (sck_fall)
				spi_miso <= tx_sh[7];
		end
	end

	// shift registers carry data only
	always_ff @(posedge ps2_clk) begin
		if (sck_rise)
			rx_sh <= {rx_sh[5:0], mosi_sync[1]};
		if (sck_rise && (bit_cnt == 3'd7))
			rx_data <= {rx_sh, mosi_sync[1]};

		if (load_q)
			tx_sh <= reply;
		else if (sck_fall)
			tx_sh <= {tx_sh[6:0], 1'b0};
	end

	// strobe is a single pulse per byte
	a_rx_single: assert property (
		@(posedge ps2_clk) disable iff (SPI_SS_IO)
		rx_stb |=> !rx_stb
	);

endmodule

// File: hdl/user_io_pkg.sv
//////////////////////////////////////////////////
// user i/o shared definitions
// byte and axis types, command codes, fsm states
// and the structs passed between the blocks
//////////////////////////////////////////////////

package user_io_pkg;

	// plain data byte as it travels over spi
	typedef logic [7:0] byte_t;

	// analog axis pair, x in [15:8], y in [7:0]
	typedef logic [15:0] word_t;

	// core type, returned during every command byte
	localparam byte_t core_type = 8'ha4;

	// configuration string, sent first byte first
	localparam int conf_len = 8;
	localparam logic [8*conf_len-1:0] conf_text = "MIST;UIO";

	// each ps2 fifo holds 2**ps2_fifo_bits bytes
	localparam int ps2_fifo_bits = 3;

	// last transmitter state, the stop bit
	localparam logic [3:0] ps2_last_state = 4'd11;

	// commands understood by the controller
	typedef enum logic [7:0] {
		cmd_none     = 8'h00,
		cmd_but_sw   = 8'h01,
		cmd_joy_0    = 8'h02,
		cmd_joy_1    = 8'h03,
		cmd_mouse    = 8'h04,
		cmd_kbd      = 8'h05,
		cmd_get_conf = 8'h14,
		cmd_status   = 8'h15,
		cmd_analog   = 8'h1a
	} cmd_e;

	// in-band framing: command, length, payload
	typedef enum logic [1:0] {
		st_cmd,
		st_len,
		st_data
	} frame_state_e;

	// one payload byte heading for the register bank
	typedef struct packed {
		logic  stb;
		cmd_e  cmd;
		byte_t idx;
		byte_t data;
	} reg_wr_t;

	// byte assembled from mosi
	typedef struct packed {
		logic  stb;
		byte_t data;
	} rx_byte_t;

endpackage

// File: hdl/user_io_top.sv
//////////////////////////////////////////////////
// user i/o top level
// spi byte port, command controller, register
// bank and the keyboard and mouse ps2 channels
//////////////////////////////////////////////////

`timescale 1ns/1ps

module user_io_top (
	input  logic               ps2_clk,
	input  logic               SPI_SS_IO,
	input  logic               spi_clk,
	input  logic               spi_mosi,
	output logic               spi_miso,
	output logic [1:0]         buttons,
	output logic [1:0]         switches,
	output logic               scandoubler_disable,
	output user_io_pkg::byte_t joystick_0,
	output user_io_pkg::byte_t joystick_1,
	output user_io_pkg::byte_t status,
	output user_io_pkg::word_t joystick_analog_0,
	output user_io_pkg::word_t joystick_analog_1,
	output logic               ps2_kbd_clk,
	output logic               ps2_kbd_data,
	output logic               ps2_mouse_clk,
	output logic               ps2_mouse_data
);
	import user_io_pkg::*;

	// port to controller and back
	rx_byte_t rx;
	byte_t    reply;
	// controller to bank and fifos
	reg_wr_t  reg_wr;
	logic     kbd_push;
	logic     mouse_push;
	byte_t    push_data;

	spi_byte_port i_spi_byte_port (
		.ps2_clk   (ps2_clk),
		.SPI_SS_IO (SPI_SS_IO),
		.spi_clk   (spi_clk),
		.spi_mosi  (spi_mosi),
		.reply     (reply),
		.spi_miso  (spi_miso),
		.rx        (rx)
	);

	io_cmd_ctrl i_io_cmd_ctrl (
		.ps2_clk    (ps2_clk),
		.SPI_SS_IO  (SPI_SS_IO),
		.rx         (rx),
		.reply      (reply),
		.reg_wr     (reg_wr),
		.kbd_push   (kbd_push),
		.mouse_push (mouse_push),
		.push_data  (push_data)
	);

	io_reg_bank i_io_reg_bank (
		.ps2_clk             (ps2_clk),
		.SPI_SS_IO           (SPI_SS_IO),
		.reg_wr              (reg_wr),
		.buttons             (buttons),
		.switches            (switches),
		.scandoubler_disable (scandoubler_disable),
		.joystick_0          (joystick_0),
		.joystick_1          (joystick_1),
		.status              (status),
		.joystick_analog_0   (joystick_analog_0),
		.joystick_analog_1   (joystick_analog_1)
	);

	// keyboard channel
	ps2_tx_fifo kbd_tx (
		.ps2_clk      (ps2_clk),
		.SPI_SS_IO    (SPI_SS_IO),
		.push         (kbd_push),
		.push_data    (push_data),
		.ps2_dev_clk  (ps2_kbd_clk),
		.ps2_dev_data (ps2_kbd_data)
	);

	// mouse channel
	ps2_tx_fifo mouse_tx (
		.ps2_clk      (ps2_clk),
		.SPI_SS_IO    (SPI_SS_IO),
		.push         (mouse_push),
		.push_data    (push_data),
		.ps2_dev_clk  (ps2_mouse_clk),
		.ps2_dev_data (ps2_mouse_data)
	);

endmodule

// File: tb/spi_host_tasks.svh
//////////////////////////////////////////////////
// spi host side of the user i/o testbench
// bit-level byte exchange and framed commands
//////////////////////////////////////////////////

`ifndef SPI_HOST_TASKS_SVH
`define SPI_HOST_TASKS_SVH

// spi clock half period in ps2_clk cycles
localparam int spi_half = 8;

// payload going out, replies coming back
byte_t tx_buf [16];
byte_t rx_buf [16];
// replies seen during the command and length bytes
byte_t cmd_reply;
byte_t len_reply;

// one byte each way, msb first
// mosi changes with the clock low, miso is read late in the low phase
task automatic shift_byte(input byte_t tx, output byte_t rx);
	for (int i = 7; i >= 0; i--) begin
		@(posedge ps2_clk);
		spi_clk  <= 1'b0;
		spi_mosi <= tx[i];
		repeat (spi_half - 1) @(posedge ps2_clk);
		@(negedge ps2_clk);
		rx[i] = spi_miso;
		// rising edge, the core samples mosi here
		@(posedge ps2_clk);
		spi_clk <= 1'b1;
		repeat (spi_half - 1) @(posedge ps2_clk);
	end
endtask

// command byte, length byte, then len payload bytes from tx_buf
task automatic send_cmd(input byte_t cmd, input int len);
	shift_byte(cmd, cmd_reply);
	shift_byte(byte_t'(len), len_reply);
	for (int i = 0; i < len; i++)
		shift_byte(tx_buf[i], rx_buf[i]);
	// give the last register write time to land
	repeat (2) @(posedge ps2_clk);
endtask

`endif

// File: tb/user_io_tb.sv
//////////////////////////////////////////////////
// user i/o testbench
// random spi commands against a register and
// ps2 stream model, frames rebuilt from the pins
//////////////////////////////////////////////////

`timescale 1ns/1ps

module user_io_tb;
	import user_io_pkg::*;

	localparam int max_cycles = 400000;
	// core type and config string as the host expects them
	localparam byte_t exp_core = 8'ha4;
	localparam logic [63:0] exp_conf = "MIST;UIO";

	logic        ps2_clk = 1'b0;
	logic        SPI_SS_IO;
	logic        spi_clk;
	logic        spi_mosi;
	logic        spi_miso;
	logic [1:0]  buttons;
	logic [1:0]  switches;
	logic        scandoubler_disable;
	byte_t       joystick_0;
	byte_t       joystick_1;
	byte_t       status;
	word_t       joystick_analog_0;
	word_t       joystick_analog_1;
	logic        ps2_kbd_clk;
	logic        ps2_kbd_data;
	logic        ps2_mouse_clk;
	logic        ps2_mouse_data;

	// reference model
	logic [4:0]  exp_but_sw;
	byte_t       exp_joy [2];
	byte_t       exp_status;
	word_t       exp_ana [2];
	byte_t       kbd_q [$];
	byte_t       mouse_q [$];

	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          test_errs = 0;

	// frame capture, bit 0 is the start bit once complete
	logic [10:0] kbd_frame;
	logic [10:0] mouse_frame;
	int          kbd_bits = 0;
	int          mouse_bits = 0;

	`include "spi_host_tasks.svh"

	always #50 ps2_clk = ~ps2_clk;

	user_io_top i_user_io_top (.*);

	// hang guard
	always @(posedge ps2_clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("run stopped after %0d cycles, something hung", cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	function automatic void check_val(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %h exp %h", name, got, exp);
		end
	endfunction

	function automatic void check_regs();
		check_val("buttons", buttons, exp_but_sw[1:0]);
		check_val("switches", switches, exp_but_sw[3:2]);
		check_val("scandoubler_disable", scandoubler_disable, exp_but_sw[4]);
		check_val("joystick_0", joystick_0, exp_joy[0]);
		check_val("joystick_1", joystick_1, exp_joy[1]);
		check_val("status", status, exp_status);
		check_val("joystick_analog_0", joystick_analog_0, exp_ana[0]);
		check_val("joystick_analog_1", joystick_analog_1, exp_ana[1]);
	endfunction

	// start 0, data, odd parity over data plus parity bit, stop 1
	function automatic void check_frame(input string name, input logic [10:0] f,
		input byte_t exp);
		check_val({name, " start"}, f[0], 1'b0);
		check_val({name, " data"}, f[8:1], exp);
		check_val({name, " parity"}, f[9], ~^exp);
		check_val({name, " stop"}, f[10], 1'b1);
	endfunction

	// model update, straight from the command rules
	function automatic void model_cmd(input byte_t cmd, input int len);
		byte_t last;
		if (len > 0) begin
			last = tx_buf[len-1];
			case (cmd)
				8'h01: exp_but_sw = last[4:0];
				8'h02: exp_joy[0] = last;
				8'h03: exp_joy[1] = last;
				8'h15: exp_status = last;
				// stick index, then x high, y low; sticks 2 and up are ignored
				8'h1a: if (tx_buf[0] < 2) exp_ana[tx_buf[0]] = {tx_buf[1], tx_buf[2]};
				8'h04: for (int i = 0; i < len; i++) mouse_q.push_back(tx_buf[i]);
				8'h05: for (int i = 0; i < len; i++) kbd_q.push_back(tx_buf[i]);
				default: ;
			endcase
		end
	endfunction

	function automatic void fill_payload(input int len);
		for (int i = 0; i < len; i++)
			tx_buf[i] = byte_t'($urandom);
	endfunction

	function automatic byte_t pick_reg_cmd();
		case ($urandom % 4)
			0: return 8'h01;
			1: return 8'h02;
			2: return 8'h03;
			default: return 8'h15;
		endcase
	endfunction

	function automatic bit is_known(input byte_t code);
		case (code)
			8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 8'h14, 8'h15, 8'h1a: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic void end_test(input string name);
		if (errors == test_errs)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - test_errs);
		test_errs = errors;
	endfunction

	// model first so frames that finish mid-command find their byte queued
	task automatic issue(input byte_t cmd, input int len);
		model_cmd(cmd, len);
		send_cmd(cmd, len);
		check_val("spi_miso cmd reply", cmd_reply, exp_core);
		check_val("spi_miso len reply", len_reply, 8'h00);
		// only the config command answers its payload with data
		if (cmd != 8'h14)
			for (int i = 0; i < len; i++)
				check_val("spi_miso data reply", rx_buf[i], 8'h00);
		@(negedge ps2_clk);
		check_regs();
	endtask

	task automatic wait_ps2_idle();
		int n;
		n = 0;
		while ((kbd_q.size() + mouse_q.size() != 0) && (n < 1000)) begin
			@(posedge ps2_clk);
			n++;
		end
		if (n >= 1000) begin
			errors++;
			$display("ps2 bytes still pending after %0d cycles", n);
			kbd_q.delete();
			mouse_q.delete();
		end
		@(negedge ps2_clk);
		check_val("ps2_kbd_clk", ps2_kbd_clk, 1'b1);
		check_val("ps2_mouse_clk", ps2_mouse_clk, 1'b1);
		check_val("ps2_kbd_data", ps2_kbd_data, 1'b1);
		check_val("ps2_mouse_data", ps2_mouse_data, 1'b1);
	endtask

	// data is stable while the device clock is low
	always @(negedge ps2_kbd_clk) begin
		kbd_frame = {ps2_kbd_data, kbd_frame[10:1]};
		kbd_bits  = kbd_bits + 1;
		if (kbd_bits == 11) begin
			kbd_bits = 0;
			if (kbd_q.size() == 0) begin
				errors++;
				$display("keyboard frame %h arrived with no byte expected", kbd_frame);
			end else
				check_frame("ps2_kbd_data", kbd_frame, kbd_q.pop_front());
		end
	end

	always @(negedge ps2_mouse_clk) begin
		mouse_frame = {ps2_mouse_data, mouse_frame[10:1]};
		mouse_bits  = mouse_bits + 1;
		if (mouse_bits == 11) begin
			mouse_bits = 0;
			if (mouse_q.size() == 0) begin
				errors++;
				$display("mouse frame %h arrived with no byte expected", mouse_frame);
			end else
				check_frame("ps2_mouse_data", mouse_frame, mouse_q.pop_front());
		end
	end

	initial begin
		byte_t cmd;
		byte_t code;
		int    len;
		void'($urandom(89));
		SPI_SS_IO  = 1'b1;
		spi_clk    = 1'b1;
		spi_mosi   = 1'b0;
		exp_but_sw = '0;
		exp_joy    = '{8'h00, 8'h00};
		exp_status = '0;
		exp_ana    = '{16'h0000, 16'h0000};
		repeat (16) @(posedge ps2_clk);
		SPI_SS_IO <= 1'b0;

		// everything cleared, ps2 lines idle high
		repeat (2) @(negedge ps2_clk);
		check_regs();
		check_val("spi_miso", spi_miso, 1'b0);
		check_val("ps2_kbd_clk", ps2_kbd_clk, 1'b1);
		check_val("ps2_kbd_data", ps2_kbd_data, 1'b1);
		check_val("ps2_mouse_clk", ps2_mouse_clk, 1'b1);
		check_val("ps2_mouse_data", ps2_mouse_data, 1'b1);
		end_test("reset state");

		for (int n = 0; n < 200; n++) begin
			cmd = pick_reg_cmd();
			len = 1 + $urandom % 3;
			fill_payload(len);
			issue(cmd, len);
		end
		end_test("register writes");

		for (int n = 0; n < 30; n++) begin
			fill_payload(3);
			tx_buf[0] = byte_t'($urandom % 4);
			issue(8'h1a, 3);
		end
		end_test("analog joysticks");

		// config text first byte first, zeros past its end
		for (int n = 0; n < 16; n++) begin
			len = 1 + $urandom % 12;
			fill_payload(len);
			issue(8'h14, len);
			for (int i = 0; i < len; i++)
				check_val("spi_miso conf byte", rx_buf[i],
					(i < 8) ? exp_conf[8*(7-i) +: 8] : 8'h00);
		end
		end_test("config replies");

		for (int n = 0; n < 24; n++) begin
			len = 1 + $urandom % 8;
			fill_payload(len);
			issue(($urandom % 2) ? 8'h05 : 8'h04, len);
			wait_ps2_idle();
		end
		end_test("ps2 streams");

		// unknown code skipped by its length, next command still decoded
		for (int n = 0; n < 16; n++) begin
			do
				code = byte_t'($urandom);
			while (is_known(code));
			len = $urandom % 8;
			fill_payload(len);
			issue(code, len);
			fill_payload(2);
			issue(pick_reg_cmd(), 2);
		end
		wait_ps2_idle();
		end_test("unknown commands");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: user_io_top.f
+incdir+tb
hdl/user_io_pkg.sv
hdl/spi_byte_port.sv
hdl/io_cmd_ctrl.sv
hdl/io_reg_bank.sv
hdl/ps2_tx_fifo.sv
hdl/user_io_top.sv
tb/user_io_tb.sv
